//--- common/gamma_regs_pkg.sv
// register map, Wishbone request struct and configuration struct
// for the pixel correction engine
`default_nettype none

package gamma_regs_pkg;

    // correction factor, pixel multiplied by factor + 1
    localparam int FACTOR_W = 3;

    // Wishbone bus geometry
    localparam int WB_ADR_W = 4;
    localparam int WB_DAT_W = 32;
    localparam int WB_SEL_W = 4;

    // word addresses
    localparam logic [WB_ADR_W-1:0] REG_CTRL  = 4'd0;
    localparam logic [WB_ADR_W-1:0] REG_COUNT = 4'd1;

    // control register fields
    localparam int CTRL_FACTOR_LSB = 0;
    localparam int CTRL_SAT_BIT    = 8;

    // corrected pixel counter, read only
    localparam int COUNT_W = 16;

    // host side of a Wishbone classic cycle
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0] dat;
        logic [WB_SEL_W-1:0] sel;
    } wb_req_t;

    // settings applied to each pixel
    typedef struct packed {
        logic [FACTOR_W-1:0] factor;
        logic                sat;
    } gamma_cfg_t;

endpackage

`default_nettype wire

//--- common/pixel_pkg.sv
// pixel word width and pixel stream struct
`default_nettype none

package pixel_pkg;

    // grayscale pixel width
    localparam int PIX_W = 8;

    // one pixel on the stream, qualified by valid
    typedef struct packed {
        logic             valid;
        logic [PIX_W-1:0] data;
    } pix_t;

endpackage

`default_nettype wire

//--- hw/gamma_wb_regs.sv
// Wishbone classic slave with the control register and
// the corrected pixel counter
`default_nettype none

module gamma_wb_regs (
    input  logic                                clk,
    input  logic                                reset,
    input  gamma_regs_pkg::wb_req_t             wb_req,
    output logic                                wb_ack,
    output logic [gamma_regs_pkg::WB_DAT_W-1:0] wb_dat_r,
    input  logic                                count_pulse,
    output gamma_regs_pkg::gamma_cfg_t          cfg
);
    import gamma_regs_pkg::*;

    logic                req;
    logic                access;
    logic [COUNT_W-1:0]  pixel_count;
    logic [WB_DAT_W-1:0] read_word;

    assign req = wb_req.cyc & wb_req.stb;

    // first cycle of a request only
    // a high ack forces the gap cycle after it
    assign access = req & ~wb_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= access;
        end
    end

    // control register, byte 0 holds the factor, byte 1 the saturate flag
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg <= '0;
        end else if (access && wb_req.we && wb_req.adr == REG_CTRL) begin
            if (wb_req.sel[0]) begin
                cfg.factor <= wb_req.dat[CTRL_FACTOR_LSB +: FACTOR_W];
            end
            if (wb_req.sel[1]) begin
                cfg.sat <= wb_req.dat[CTRL_SAT_BIT];
            end
        end
    end

    // counts corrected pixels, wraps at 16 bits
    always_ff @(posedge clk) begin
        if (reset) begin
            pixel_count <= '0;
        end else if (count_pulse) begin
            pixel_count <= pixel_count + 1'b1;
        end
    end

    // read mux, unmapped words read as zero
    always_comb begin
        read_word = '0;
        case (wb_req.adr)
            REG_CTRL: begin
                read_word[CTRL_FACTOR_LSB +: FACTOR_W] = cfg.factor;
                read_word[CTRL_SAT_BIT]                = cfg.sat;
            end
            REG_COUNT: read_word[COUNT_W-1:0] = pixel_count;
            default:   read_word = '0;
        endcase
    end

    // read data lands together with ack
    always_ff @(posedge clk) begin
        if (access && !wb_req.we) begin
            wb_dat_r <= read_word;
        end
    end

endmodule

`default_nettype wire

//--- gamma_lut/gamma_lut_manager.sv
// pixel input stage, correction table built at elaboration
// and the saturating or truncating lookup
`default_nettype none

module gamma_lut_manager #(
    parameter int PIXEL_W = pixel_pkg::PIX_W
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       enable,
    input  logic [PIXEL_W-1:0]         pixel_in,
    input  gamma_regs_pkg::gamma_cfg_t cfg,
    output pixel_pkg::pix_t            stage
);
    import gamma_regs_pkg::*;

    localparam int NUM_FACTORS = 2 ** FACTOR_W;
    localparam int NUM_PIXELS  = 2 ** PIXEL_W;
    // widest product is max pixel times 2**FACTOR_W
    localparam int PROD_W      = PIXEL_W + FACTOR_W;
    localparam logic [PIXEL_W-1:0] PIX_MAX = '1;

    logic [PROD_W-1:0]  lut [NUM_FACTORS][NUM_PIXELS];
    logic               valid_q;
    logic [PIXEL_W-1:0] pix_q;
    gamma_cfg_t         cfg_q;
    logic [PROD_W-1:0]  product;
    logic [PIXEL_W-1:0] result;

    // table entry is pixel times (factor + 1)
    for (genvar f = 0; f < NUM_FACTORS; f++) begin : g_factor
        for (genvar p = 0; p < NUM_PIXELS; p++) begin : g_pixel
            assign lut[f][p] = PROD_W'(p * (f + 1));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= enable;
        end
    end

    // pixel travels with the cfg it entered under
    always_ff @(posedge clk) begin
        if (enable) begin
            pix_q <= pixel_in;
            cfg_q <= cfg;
        end
    end

    assign product = lut[cfg_q.factor][pix_q];

    always_comb begin
        if (cfg_q.sat && product > PROD_W'(PIX_MAX)) begin
            result = PIX_MAX;
        end else begin
            result = product[PIXEL_W-1:0];
        end
    end

    assign stage.valid = valid_q;
    assign stage.data  = result;

endmodule

`default_nettype wire

//--- hw/output_register_handler.sv
// output pixel register, valid flag and counter pulse
`default_nettype none

module output_register_handler #(
    parameter int PIXEL_W = pixel_pkg::PIX_W
) (
    input  logic               clk,
    input  logic               reset,
    input  pixel_pkg::pix_t    stage,
    output logic [PIXEL_W-1:0] pixel_out,
    output logic               pixel_valid,
    output logic               count_pulse
);

    // holds the last corrected pixel between valid ones
    always_ff @(posedge clk) begin
        if (reset) begin
            pixel_out <= '0;
        end else if (stage.valid) begin
            pixel_out <= stage.data;
        end
    end

    // count_pulse trails pixel_valid by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            pixel_valid <= 1'b0;
            count_pulse <= 1'b0;
        end else begin
            pixel_valid <= stage.valid;
            count_pulse <= pixel_valid;
        end
    end

endmodule

`default_nettype wire

//--- hw/gamma_correction_codec.sv
// top level of the pixel correction engine
// Wishbone slave, lookup stage and output register
`default_nettype none

module gamma_correction_codec #(
    parameter int PIXEL_W = pixel_pkg::PIX_W
) (
    input  logic                                clk,
    input  logic                                reset,
    input  gamma_regs_pkg::wb_req_t             wb_req,
    output logic                                wb_ack,
    output logic [gamma_regs_pkg::WB_DAT_W-1:0] wb_dat_r,
    input  logic                                enable,
    input  logic [PIXEL_W-1:0]                  pixel_in,
    output logic [PIXEL_W-1:0]                  pixel_out,
    output logic                                pixel_valid
);
    import gamma_regs_pkg::*;
    import pixel_pkg::*;

    gamma_cfg_t cfg;
    pix_t       stage;
    logic       count_pulse;

    gamma_wb_regs i_regs (
        .clk         (clk),
        .reset       (reset),
        .wb_req      (wb_req),
        .wb_ack      (wb_ack),
        .wb_dat_r    (wb_dat_r),
        .count_pulse (count_pulse),
        .cfg         (cfg)
    );

    // one register stage, then combinational lookup
    gamma_lut_manager #(
        .PIXEL_W (PIXEL_W)
    ) i_lut (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .pixel_in (pixel_in),
        .cfg      (cfg),
        .stage    (stage)
    );

    output_register_handler #(
        .PIXEL_W (PIXEL_W)
    ) i_out (
        .clk         (clk),
        .reset       (reset),
        .stage       (stage),
        .pixel_out   (pixel_out),
        .pixel_valid (pixel_valid),
        .count_pulse (count_pulse)
    );

endmodule

`default_nettype wire

//--- testbench/gamma_correction_checker.sv
// concurrent checks on Wishbone ack, pixel latency and corrected value
`default_nettype none

module gamma_correction_checker #(
    parameter int PIXEL_W = 8
) (
    input logic                       clk,
    input logic                       reset,
    input gamma_regs_pkg::wb_req_t    wb_req,
    input logic                       wb_ack,
    input logic                       enable,
    input logic [PIXEL_W-1:0]         pixel_in,
    input gamma_regs_pkg::gamma_cfg_t cfg,
    input logic                       pixel_valid,
    input logic [PIXEL_W-1:0]         pixel_out
);
    timeunit 1ns;
    timeprecision 100ps;

    import gamma_regs_pkg::*;

    int   fail_count = 0;
    logic req;

    assign req = wb_req.cyc && wb_req.stb;

    // pixel times (factor + 1), clamped to the maximum or cut to the pixel width
    function automatic logic [PIXEL_W-1:0] corrected(input logic [PIXEL_W-1:0] pix,
                                                     input gamma_cfg_t c);
        int product;
        int pix_max;
        product = int'(pix) * (int'(c.factor) + 1);
        pix_max = (1 << PIXEL_W) - 1;
        if (c.sat && product > pix_max) begin
            return '1;
        end
        return PIXEL_W'(product);
    endfunction

    ack_after_request: assert property (@(posedge clk) disable iff (reset)
        req && !wb_ack |=> wb_ack)
        else begin
            fail_count = fail_count + 1;
            $error("ack missing one cycle after a new request");
        end

    ack_gap: assert property (@(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack)
        else begin
            fail_count = fail_count + 1;
            $error("ack held for more than one cycle");
        end

    ack_needs_request: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> req)
        else begin
            fail_count = fail_count + 1;
            $error("ack seen without cyc and stb");
        end

    // two cycles from enable to valid
    valid_latency: assert property (@(posedge clk) disable iff (reset)
        pixel_valid == $past(enable, 2))
        else begin
            fail_count = fail_count + 1;
            $error("pixel_valid does not follow enable by two cycles");
        end

    pixel_value: assert property (@(posedge clk) disable iff (reset)
        pixel_valid |-> pixel_out == corrected($past(pixel_in, 2), $past(cfg, 2)))
        else begin
            fail_count = fail_count + 1;
            $error("pixel_out %h differs from the corrected input pixel", pixel_out);
        end

    // output keeps the last pixel between valid ones
    pixel_hold: assert property (@(posedge clk) disable iff (reset)
        !pixel_valid |-> $stable(pixel_out))
        else begin
            fail_count = fail_count + 1;
            $error("pixel_out changed while pixel_valid was low");
        end

    reset_outputs: assert property (@(posedge clk)
        $fell(reset) |-> !pixel_valid && !wb_ack)
        else begin
            fail_count = fail_count + 1;
            $error("pixel_valid or wb_ack high right after reset");
        end

endmodule

`default_nettype wire

//--- testbench/gamma_correction_tb.sv
// testbench for the pixel correction engine
// Wishbone and pixel stimulus, read-back checks and watchdog
`default_nettype none

module gamma_correction_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import gamma_regs_pkg::*;

    localparam int PIXEL_W   = 8;
    localparam int ACK_LIMIT = 16;
    // all tests fit in about 1000 cycles, twice that
    localparam int WATCHDOG_CYCLES = 2000;

    logic                clk;
    logic                reset;
    wb_req_t             wb_req;
    logic                wb_ack;
    logic [WB_DAT_W-1:0] wb_dat_r;
    logic                enable;
    logic [PIXEL_W-1:0]  pixel_in;
    logic [PIXEL_W-1:0]  pixel_out;
    logic                pixel_valid;

    int readback_errors = 0;
    int timeout_errors  = 0;
    int enabled_count   = 0;

    gamma_correction_codec #(
        .PIXEL_W (PIXEL_W)
    ) i_dut (
        .clk         (clk),
        .reset       (reset),
        .wb_req      (wb_req),
        .wb_ack      (wb_ack),
        .wb_dat_r    (wb_dat_r),
        .enable      (enable),
        .pixel_in    (pixel_in),
        .pixel_out   (pixel_out),
        .pixel_valid (pixel_valid)
    );

    bind gamma_correction_codec gamma_correction_checker #(
        .PIXEL_W (PIXEL_W)
    ) i_checker (
        .clk         (clk),
        .reset       (reset),
        .wb_req      (wb_req),
        .wb_ack      (wb_ack),
        .enable      (enable),
        .pixel_in    (pixel_in),
        .cfg         (cfg),
        .pixel_valid (pixel_valid),
        .pixel_out   (pixel_out)
    );

    always #10 clk = ~clk;

    // one classic cycle, stb dropped on the edge that shows ack
    task automatic bus_cycle(input logic we, input logic [WB_ADR_W-1:0] adr,
                             input logic [WB_DAT_W-1:0] dat, input logic [3:0] sel);
        wb_req_t req;
        int      waited;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.adr = adr;
        req.dat = dat;
        req.sel = sel;
        waited  = 0;
        @(posedge clk);
        wb_req <= req;
        do begin
            @(posedge clk);
            waited++;
        end while (!wb_ack && waited < ACK_LIMIT);
        wb_req <= '0;
        if (!wb_ack) begin
            timeout_errors++;
            $display("no Wishbone ack within %0d cycles at %0d ns", ACK_LIMIT, $time);
        end
    endtask

    task automatic write_reg(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] dat,
                             input logic [3:0] sel);
        bus_cycle(1'b1, adr, dat, sel);
    endtask

    task automatic read_expect(input logic [WB_ADR_W-1:0] adr,
                               input logic [WB_DAT_W-1:0] expected);
        bus_cycle(1'b0, adr, '0, 4'hF);
        if (wb_dat_r !== expected) begin
            readback_errors++;
            $display("[FAIL] %0d ns wb_dat_r (adr %0d) expected %h actual %h",
                     $time, adr, expected, wb_dat_r);
        end
    endtask

    task automatic drive_pixel(input logic [PIXEL_W-1:0] value);
        @(posedge clk);
        enable   <= 1'b1;
        pixel_in <= value;
        enabled_count++;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            enable <= 1'b0;
        end
    endtask

    task automatic finish_run();
        int assertion_errors;
        assertion_errors = i_dut.i_checker.fail_count;
        $display("errors: readback %0d, assertion %0d, timeout %0d",
                 readback_errors, assertion_errors, timeout_errors);
        if (readback_errors + assertion_errors + timeout_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    initial begin
        void'($urandom(52));
        clk      = 1'b0;
        reset    = 1'b1;
        wb_req   = '0;
        enable   = 1'b0;
        pixel_in = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        read_expect(REG_CTRL, '0);
        read_expect(REG_COUNT, '0);

        // factor 5 with sat, then a factor-only byte write
        write_reg(REG_CTRL, 32'h105, 4'hF);
        read_expect(REG_CTRL, 32'h105);
        write_reg(REG_CTRL, 32'h002, 4'h1);
        read_expect(REG_CTRL, 32'h102);
        // unmapped word right after a non-zero read
        read_expect(4'd8, '0);
        write_reg(REG_COUNT, 32'h1234, 4'hF);
        read_expect(REG_COUNT, '0);

        // truncating, every factor
        for (int f = 0; f < 8; f++) begin
            write_reg(REG_CTRL, WB_DAT_W'(f), 4'hF);
            repeat (32) drive_pixel(PIXEL_W'($urandom));
            idle(3);
        end

        // saturating at factor 7
        write_reg(REG_CTRL, 32'h107, 4'hF);
        drive_pixel(8'd0);
        drive_pixel(8'd31);
        drive_pixel(8'd32);
        drive_pixel(8'd255);
        idle(3);

        // stream with gaps while the factor changes underneath
        fork
            begin
                for (int i = 0; i < 80; i++) begin
                    if ($urandom % 4 == 0) begin
                        idle(1);
                    end else begin
                        drive_pixel(PIXEL_W'($urandom));
                    end
                end
                idle(3);
            end
            begin
                write_reg(REG_CTRL, 32'h003, 4'hF);
                repeat (12) @(posedge clk);
                write_reg(REG_CTRL, 32'h106, 4'hF);
                repeat (9) @(posedge clk);
                write_reg(REG_CTRL, 32'h001, 4'hF);
            end
        join

        idle(2);
        read_expect(REG_COUNT, WB_DAT_W'(enabled_count));
        finish_run();
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        timeout_errors++;
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        finish_run();
    end

endmodule

`default_nettype wire

//--- vlog.f
common/gamma_regs_pkg.sv
common/pixel_pkg.sv
hw/gamma_wb_regs.sv
gamma_lut/gamma_lut_manager.sv
hw/output_register_handler.sv
hw/gamma_correction_codec.sv
testbench/gamma_correction_checker.sv
testbench/gamma_correction_tb.sv

//--- Makefile
# Verilator lint, simulation and clean for the pixel correction engine

VERILATOR   ?= verilator
TOP         ?= gamma_correction_tb
FILELIST    ?= vlog.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
TIMESCALE   ?= 1ns/100ps
LINT_FLAGS  ?= --lint-only --timing --timescale $(TIMESCALE)
BUILD_FLAGS ?= --binary --timing --assert --timescale $(TIMESCALE) -j 0
SIM_ARGS    ?= +verilator+error+limit+1000
PASS_TEXT   ?= RESULT: PASS

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
